//--- source/mems_pkg.sv
package mems_pkg;

  localparam int ADDR_W     = 17;
  localparam int ROM_ADDR_W = 15;
  localparam int LEVEL_W    = 16;
  localparam int DAC_W      = 24;
  localparam int NUM_CH     = 4;
  localparam int UNIT_W     = 3;  // room for up to 8 units

  localparam logic [LEVEL_W-1:0] HOME_BIAS = 16'd23250;  // mirror rest level
  localparam logic [LEVEL_W-1:0] HOME_STEP = 16'd30;
  localparam logic [LEVEL_W-1:0] BIAS_X2   = 16'hB650;   // measured on the scope

  // C and D are the differential channels
  typedef enum logic [1:0] {
    CH_A = 2'b00,
    CH_C = 2'b01,
    CH_B = 2'b10,
    CH_D = 2'b11
  } channel_e;

  typedef enum logic [1:0] {
    CMD_SOFT_RESET,
    CMD_VREF,
    CMD_WRITE
  } cmd_kind_e;

  typedef struct packed {
    cmd_kind_e kind;
    channel_e  ch;
  } dac_cmd_t;

  typedef struct packed {
    logic [ROM_ADDR_W-1:0] rom_idx;  // waveform word index
    logic [1:0]            low;
  } rom_view_t;

  typedef struct packed {
    logic [ADDR_W-4:0] upper;
    channel_e          ch;
    logic              data_phase;  // low on vref samples
  } cmd_view_t;

  typedef union packed {
    rom_view_t rom_view;
    cmd_view_t cmd_view;
  } sample_addr_u;

  typedef struct packed {
    logic               valid;
    logic [UNIT_W-1:0]  unit;
    channel_e           ch;
    logic [LEVEL_W-1:0] level;
  } rom_load_t;

  typedef struct packed {
    logic [5:0]         opcode;
    channel_e           ch;
    logic [LEVEL_W-1:0] level;
  } dac_word_t;

  localparam logic [5:0] OP_SOFT_RESET = 6'b001010;
  localparam logic [5:0] OP_VREF       = 6'b001110;  // internal reference on
  localparam logic [5:0] OP_WRITE      = 6'b000110;  // write and update channel

endpackage

//--- source/mems_cmd_decode.sv
`timescale 1ns/1ps

module mems_cmd_decode
  import mems_pkg::*;
(
  input  sample_addr_u sample_addr,
  output dac_cmd_t     cmd
);

  logic is_reset;
  logic is_vref;

  assign is_reset = (sample_addr == ADDR_W'(0));  // first sample of a sweep
  assign is_vref  = (sample_addr == ADDR_W'(1)) || !sample_addr.cmd_view.data_phase;

  always_comb begin
    cmd.ch = sample_addr.cmd_view.ch;  // homing and fetch need it for every kind
    if (is_reset) begin
      cmd.kind = CMD_SOFT_RESET;
    end else if (is_vref) begin
      cmd.kind = CMD_VREF;  // every other sample refreshes vref
    end else begin
      cmd.kind = CMD_WRITE;
    end
  end

endmodule

//--- source/mems_sample_fetch.sv
`timescale 1ns/1ps

module mems_sample_fetch
  import mems_pkg::*;
#(
  parameter int NUM_UNITS = 6
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            go_home,
  input  sample_addr_u [NUM_UNITS-1:0]    sample_addr,
  input  logic         [LEVEL_W-1:0]      rom_data,
  output logic         [ROM_ADDR_W-1:0]   rom_addr,
  output rom_load_t                       load
);

  localparam logic [1:0]        SLOT_LAST = 2'd2;  // three cycles per unit
  localparam logic [UNIT_W-1:0] UNIT_LAST = UNIT_W'(NUM_UNITS - 1);

  logic [UNIT_W-1:0]  unit_idx;
  logic [1:0]         slot_cnt;
  logic               slot_end;
  sample_addr_u       cur_addr;
  logic [LEVEL_W-1:0] rom_level;

  assign cur_addr = sample_addr[unit_idx];
  assign slot_end = (slot_cnt == SLOT_LAST);

  // differential channels are mirrored around the bias
  assign rom_level = cur_addr.cmd_view.ch[0] ? BIAS_X2 - rom_data : rom_data;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      unit_idx <= '0;
      slot_cnt <= '0;
      rom_addr <= '0;
      load     <= '0;
    end else if (go_home) begin
      slot_cnt   <= '0;  // unit index held
      load.valid <= 1'b0;
    end else begin
      rom_addr   <= cur_addr.rom_view.rom_idx;
      load.valid <= slot_end;
      if (slot_end) begin
        slot_cnt   <= '0;
        unit_idx   <= (unit_idx == UNIT_LAST) ? '0 : unit_idx + 1'b1;
        load.unit  <= unit_idx;
        load.ch    <= cur_addr.cmd_view.ch;
        load.level <= rom_level;  // rom word of this unit is valid now
      end else begin
        slot_cnt <= slot_cnt + 1'b1;
      end
    end
  end

endmodule

//--- source/mems_level_store.sv
`timescale 1ns/1ps

module mems_level_store
  import mems_pkg::*;
#(
  parameter int NUM_UNITS  = 6,
  parameter int HOME_DIV_W = 11
) (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        go_home,
  input  rom_load_t                                   load,
  input  dac_cmd_t [NUM_UNITS-1:0]                    cmd,
  output logic     [NUM_UNITS-1:0][NUM_CH-1:0][LEVEL_W-1:0] level
);

  logic [HOME_DIV_W-1:0]             home_div;
  logic                              home_step;
  logic [NUM_UNITS-1:0][LEVEL_W-1:0] home_next;

  // slow tick so the mirrors settle gently
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      home_div <= '0;
    end else if (go_home) begin
      home_div <= home_div + 1'b1;
    end else begin
      home_div <= '0;
    end
  end

  assign home_step = go_home && (home_div == '0);  // first step right away

  always_comb begin
    for (int u = 0; u < NUM_UNITS; u++) begin
      if (level[u][cmd[u].ch] > HOME_BIAS) begin
        home_next[u] = level[u][cmd[u].ch] - HOME_STEP;
      end else begin
        home_next[u] = level[u][cmd[u].ch] + HOME_STEP;  // at bias it still steps up
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      level <= '0;
    end else begin
      if (load.valid) begin
        level[load.unit][load.ch] <= load.level;
      end
      // a step on the same channel wins over a late load
      if (home_step) begin
        for (int u = 0; u < NUM_UNITS; u++) begin
          level[u][cmd[u].ch] <= home_next[u];
        end
      end
    end
  end

endmodule

//--- source/mems_word_format.sv
`timescale 1ns/1ps

module mems_word_format
  import mems_pkg::*;
(
  input  logic                           clk,
  input  logic                           arst_n,
  input  dac_cmd_t                       cmd,
  input  logic [NUM_CH-1:0][LEVEL_W-1:0] level,
  output dac_word_t                      dac_word
);

  dac_word_t word_next;

  always_comb begin
    case (cmd.kind)
      CMD_SOFT_RESET: begin
        word_next = '{opcode: OP_SOFT_RESET, ch: CH_A, level: LEVEL_W'(1)};  // reset all regs
      end
      CMD_WRITE: begin
        word_next = '{opcode: OP_WRITE, ch: cmd.ch, level: level[cmd.ch]};
      end
      default: begin
        word_next = '{opcode: OP_VREF, ch: CH_A, level: '0};
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dac_word <= '0;
    end else begin
      dac_word <= word_next;  // one word per sample to the serializer
    end
  end

endmodule

//--- source/mems_driver_top.sv
`timescale 1ns/1ps

module mems_driver_top
  import mems_pkg::*;
#(
  parameter int NUM_UNITS  = 6,
  parameter int HOME_DIV_W = 11
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            go_home,
  input  sample_addr_u [NUM_UNITS-1:0]    sample_addr,
  input  logic         [LEVEL_W-1:0]      rom_data,
  output logic         [ROM_ADDR_W-1:0]   rom_addr,
  output dac_word_t    [NUM_UNITS-1:0]    dac_word
);

  dac_cmd_t  [NUM_UNITS-1:0]                          cmd;
  rom_load_t                                          load;
  logic      [NUM_UNITS-1:0][NUM_CH-1:0][LEVEL_W-1:0] level;

  // one time sliced ROM shared by all units
  mems_sample_fetch #(
    .NUM_UNITS (NUM_UNITS)
  ) mems_sample_fetch_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .go_home     (go_home),
    .sample_addr (sample_addr),
    .rom_data    (rom_data),
    .rom_addr    (rom_addr),
    .load        (load)
  );

  mems_level_store #(
    .NUM_UNITS  (NUM_UNITS),
    .HOME_DIV_W (HOME_DIV_W)
  ) mems_level_store_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .go_home (go_home),
    .load    (load),
    .cmd     (cmd),
    .level   (level)
  );

  for (genvar u = 0; u < NUM_UNITS; u++) begin : g_unit
    mems_cmd_decode mems_cmd_decode_inst (
      .sample_addr (sample_addr[u]),
      .cmd         (cmd[u])
    );

    mems_word_format mems_word_format_inst (
      .clk      (clk),
      .arst_n   (arst_n),
      .cmd      (cmd[u]),
      .level    (level[u]),
      .dac_word (dac_word[u])
    );
  end

endmodule

//--- verif/mems_driver_tb.sv
`timescale 1ns/1ps

module mems_driver_tb
  import mems_pkg::*;
();

  localparam int NUM_UNITS  = 6;
  localparam int HOME_DIV_W = 4;              // one homing step per 16 cycles
  localparam int ROUND      = 3 * NUM_UNITS;  // cycles per fetch round

  typedef struct packed {
    logic              is_level;
    logic [UNIT_W-1:0] unit;
    dac_word_t         word;
  } expect_t;

  logic                                          clk;
  logic                                          arst_n;
  logic                                          go_home;
  sample_addr_u [NUM_UNITS-1:0]                  sample_addr;
  logic [LEVEL_W-1:0]                            rom_data;
  logic [ROM_ADDR_W-1:0]                         rom_addr;
  dac_word_t [NUM_UNITS-1:0]                     dac_word;
  logic [ROM_ADDR_W-1:0]                         rom_q;
  logic [NUM_UNITS-1:0][NUM_CH-1:0][LEVEL_W-1:0] model_lvl;
  logic [31:0]                                   rng_state;
  expect_t                                       exp_q[$];
  int                                            err_cnt;
  int                                            check_cnt;
  int                                            test_cnt;
  int                                            test_fail;

  mems_driver_top #(
    .NUM_UNITS  (NUM_UNITS),
    .HOME_DIV_W (HOME_DIV_W)
  ) mems_driver_top_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .go_home     (go_home),
    .sample_addr (sample_addr),
    .rom_data    (rom_data),
    .rom_addr    (rom_addr),
    .dac_word    (dac_word)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // waveform content mixes every index bit
  function automatic logic [LEVEL_W-1:0] rom_word(input logic [ROM_ADDR_W-1:0] idx);
    return {idx[6:0], idx[14:6]} ^ (LEVEL_W'(idx) * 16'd37) ^ 16'h3C5A;
  endfunction

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rom_q <= '0;
    end else begin
      rom_q <= rom_addr;  // synchronous read port
    end
  end

  assign rom_data = rom_word(rom_q);

  function automatic logic [LEVEL_W-1:0] load_value(input sample_addr_u a);
    logic [LEVEL_W-1:0] d;
    d = rom_word(a.rom_view.rom_idx);
    if (a.cmd_view.ch == CH_C || a.cmd_view.ch == CH_D) begin
      return BIAS_X2 - d;  // differential pair
    end
    return d;
  endfunction

  function automatic logic [LEVEL_W-1:0] home_rule(input logic [LEVEL_W-1:0] lv);
    if (lv > HOME_BIAS) begin
      return lv - HOME_STEP;
    end
    return lv + HOME_STEP;
  endfunction

  function automatic dac_word_t ref_word(input sample_addr_u a,
                                         input logic [NUM_CH-1:0][LEVEL_W-1:0] lv);
    dac_word_t w;
    w.ch    = CH_A;
    w.level = '0;
    if (a == '0) begin
      w.opcode = OP_SOFT_RESET;
      w.level  = 16'h0001;
    end else if (a == ADDR_W'(1) || a[0] == 1'b0) begin
      w.opcode = OP_VREF;  // address phase
    end else begin
      w.opcode = OP_WRITE;
      w.ch     = channel_e'(a[2:1]);
      w.level  = lv[a[2:1]];
    end
    return w;
  endfunction

  task automatic check_word(input string name, input dac_word_t got, input dac_word_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_level(input string name, input logic [LEVEL_W-1:0] got,
                             input logic [LEVEL_W-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic push_check(input int u, input logic is_level, input dac_word_t w);
    expect_t e;
    e.is_level = is_level;
    e.unit     = UNIT_W'(u);
    e.word     = w;
    exp_q.push_back(e);
  endtask

  task automatic drain_checks();
    int n;
    n = 0;
    while (exp_q.size() > 0 && n < 4) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() > 0) begin
      $display("compare queue still holds %0d entries after 4 cycles", exp_q.size());
      err_cnt++;
    end
  endtask

  task automatic wait_word(input int u, input dac_word_t exp, input int limit);
    int n;
    n = 0;
    while (dac_word[u] !== exp && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (dac_word[u] !== exp) begin
      $display("unit %0d did not reload its level from the ROM in %0d cycles", u, limit);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    test_cnt++;
    if (err_cnt == err0) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      test_fail++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err0);
    end
  endtask

  task automatic run_write_test(input string name, input logic diff);
    int           err0;
    sample_addr_u a;
    err0 = err_cnt;
    for (int rep = 0; rep < 3; rep++) begin
      for (int u = 0; u < NUM_UNITS; u++) begin
        a = ADDR_W'(next_rand() >> 7);
        a.cmd_view.ch         = channel_e'({a[5], diff});  // A/B or C/D pair
        a.cmd_view.data_phase = 1'b1;
        if (a == ADDR_W'(1)) begin
          a.cmd_view.upper = 1;
        end
        sample_addr[u] = a;
      end
      repeat (4 * ROUND) @(negedge clk);
      for (int u = 0; u < NUM_UNITS; u++) begin
        model_lvl[u][sample_addr[u].cmd_view.ch] = load_value(sample_addr[u]);
        push_check(u, 1'b0, ref_word(sample_addr[u], model_lvl[u]));
      end
      drain_checks();
    end
    report_test(name, err0);
  endtask

  // outputs still hold the last cycle's value here
  always @(posedge clk) begin : compare
    expect_t e;
    while (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      if (e.is_level) begin
        check_level($sformatf("dac_word[%0d].level", e.unit),
                    dac_word[e.unit].level, e.word.level);
      end else begin
        check_word($sformatf("dac_word[%0d]", e.unit), dac_word[e.unit], e.word);
      end
    end
  end

  initial begin : stimulus
    int err0;
    clk         = 1'b0;
    arst_n      = 1'b0;
    go_home     = 1'b0;
    sample_addr = '0;
    model_lvl   = '0;
    rng_state   = 32'd90;
    err_cnt     = 0;
    check_cnt   = 0;
    test_cnt    = 0;
    test_fail   = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    err0 = err_cnt;
    for (int u = 0; u < NUM_UNITS; u++) begin
      push_check(u, 1'b0, '0);
    end
    drain_checks();
    report_test("reset clears dac_word", err0);

    err0 = err_cnt;
    for (int r = 0; r < 8; r++) begin
      for (int u = 0; u < NUM_UNITS; u++) begin
        if (r == 0) begin
          sample_addr[u] = '0;
        end else if (r == 1) begin
          sample_addr[u] = ADDR_W'(1);
        end else begin
          sample_addr[u] = ADDR_W'(next_rand() >> 9) & ~ADDR_W'(1);  // even
        end
      end
      @(negedge clk);
      for (int u = 0; u < NUM_UNITS; u++) begin
        push_check(u, 1'b0, ref_word(sample_addr[u], model_lvl[u]));
      end
      drain_checks();
    end
    report_test("soft reset and vref words", err0);

    run_write_test("write channels A and B", 1'b0);
    run_write_test("write channels C and D", 1'b1);

    err0 = err_cnt;
    go_home = 1'b1;
    repeat (2) @(negedge clk);  // first step at once and the word one cycle later
    for (int s = 0; s < 6; s++) begin
      for (int u = 0; u < NUM_UNITS; u++) begin
        model_lvl[u][sample_addr[u].cmd_view.ch] =
          home_rule(model_lvl[u][sample_addr[u].cmd_view.ch]);
        push_check(u, 1'b1, ref_word(sample_addr[u], model_lvl[u]));
      end
      repeat (1 << HOME_DIV_W) @(negedge clk);
    end
    go_home = 1'b0;
    for (int u = 0; u < NUM_UNITS; u++) begin
      model_lvl[u][sample_addr[u].cmd_view.ch] = load_value(sample_addr[u]);
    end
    for (int u = 0; u < NUM_UNITS; u++) begin
      wait_word(u, ref_word(sample_addr[u], model_lvl[u]), 4 * ROUND);
    end
    for (int u = 0; u < NUM_UNITS; u++) begin
      push_check(u, 1'b0, ref_word(sample_addr[u], model_lvl[u]));
    end
    drain_checks();
    report_test("homing steps and ROM reload", err0);

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             test_cnt, test_fail, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- project.f
source/mems_pkg.sv
source/mems_cmd_decode.sv
source/mems_sample_fetch.sv
source/mems_level_store.sv
source/mems_word_format.sv
source/mems_driver_top.sv
verif/mems_driver_tb.sv

//--- Bender.yml
package:
  name: mems_driver

sources:
  - files:
      - source/mems_pkg.sv
      - source/mems_cmd_decode.sv
      - source/mems_sample_fetch.sv
      - source/mems_level_store.sv
      - source/mems_word_format.sv
      - source/mems_driver_top.sv
  - target: test
    files:
      - verif/mems_driver_tb.sv
